// File: verilog/aexm_params.svh
`ifndef AEXM_PARAMS_SVH
`define AEXM_PARAMS_SVH

// Data path width
`define AEXM_DW 32

// Instruction address width
`define AEXM_IW 32

// Register file depth, r0 included
`define AEXM_NREG 32

// First fetch address after reset
`define AEXM_RESET_PC 32'h0000_0000

`endif

// File: verilog/aexmPkg.sv
`include "aexm_params.svh"

package aexmPkg;

  typedef logic [4:0] regIdxT;
  typedef logic [`AEXM_DW-1:0] wordT;

  // Major opcodes, bits 31:26 of the instruction word
  typedef enum logic [5:0] {
    ADD  = 6'h00,
    RSUB = 6'h01,
    ADDI = 6'h08,
    OR   = 6'h20,
    AND  = 6'h21,
    XOR  = 6'h22,
    BNEZ = 6'h2e,
    BEQZ = 6'h2f,
    LW   = 6'h32,
    SW   = 6'h36,
    NOP  = 6'h3f
  } opcodeE;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_RSUB = 3'd1, // B minus A
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_PASS = 3'd5
  } aluOpE;

  // Decoded instruction, 64 bits
  typedef struct packed {
    logic [1:0] spare;
    opcodeE     opcode;
    regIdxT     rd;
    regIdxT     ra;
    regIdxT     rb;
    wordT       immVal;   // Sign extended
    logic       useImm;
    aluOpE      aluOp;
    logic       isLoad;
    logic       isStore;
    logic       isBranch;
    logic       regWrite;
    logic       valid;
  } decInstT;

endpackage

// File: verilog/aexmDecodeIf.sv
`timescale 1ns/1ps

interface aexmDecodeIf;

  aexmPkg::decInstT dInst;  // Decode stage bundle
  aexmPkg::wordT xRegA;     // Execute stage operands, forwarded
  aexmPkg::wordT xRegB;
  logic xSkip;              // Taken branch squash
  logic dStall;             // Load-use hold

  modport ibufMp (
    output dInst,
    input  xSkip, dStall
  );

  modport regfMp (
    input  dInst,
    output xRegA, xRegB
  );

  modport xecuMp (
    input dInst, xRegA, xRegB
  );

  modport bpcuMp (
    input  dInst, xRegA, dStall,
    output xSkip
  );

  modport enableMp (
    input  dInst,
    output dStall
  );

endinterface

// File: verilog/aexmEnable.sv
`timescale 1ns/1ps

module aexmEnable (
  input  logic sys_clk_i,
  input  logic rstN_i,
  input  logic icacheBusy_i,
  input  logic dcacheBusy_i,
  aexmDecodeIf.enableMp dec_i,
  output logic loadPending_o,
  output logic cpuEnable_o,
  output logic icacheEnable_o,
  output logic dcacheEnable_o
);

  logic execLoadQ;               // Valid load in execute
  logic execMemQ;                // Valid load or store in execute
  aexmPkg::regIdxT execRdQ;
  logic loadPendQ;               // Load word returns this cycle
  logic hazard;

  assign cpuEnable_o = ~icacheBusy_i & ~dcacheBusy_i;

  // Conservative match on all three source fields
  assign hazard = execLoadQ && (execRdQ != '0) &&
                  ((dec_i.dInst.ra == execRdQ) || (dec_i.dInst.rb == execRdQ) ||
                   (dec_i.dInst.rd == execRdQ));
  assign dec_i.dStall = hazard;

  assign icacheEnable_o = rstN_i & cpuEnable_o & ~hazard;
  assign dcacheEnable_o = rstN_i & cpuEnable_o & execMemQ;
  assign loadPending_o  = loadPendQ;

  always_ff @(posedge sys_clk_i) begin
    if (!rstN_i) begin
      execLoadQ <= 1'b0;
      execMemQ  <= 1'b0;
      loadPendQ <= 1'b0;
    end else if (cpuEnable_o) begin
      execLoadQ <= dec_i.dInst.valid & dec_i.dInst.isLoad;
      execMemQ  <= dec_i.dInst.valid & (dec_i.dInst.isLoad | dec_i.dInst.isStore);
      loadPendQ <= execLoadQ;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_o) execRdQ <= dec_i.dInst.rd;
  end

endmodule

// File: verilog/aexmIbuf.sv
`timescale 1ns/1ps

module aexmIbuf (
  input  logic sys_clk_i,
  input  logic rstN_i,
  input  logic cpuEnable_i,
  input  aexmPkg::wordT icacheData_i,
  aexmDecodeIf.ibufMp dec_o
);

  aexmPkg::wordT wordQ;     // Last decoded word, replayed after a stall
  aexmPkg::wordT instWord;
  aexmPkg::decInstT decoded;
  logic replayQ;
  logic validQ;             // Decode slot holds a fetched word
  logic kill;

  assign instWord = replayQ ? wordQ : icacheData_i;
  assign kill = dec_o.xSkip | dec_o.dStall;

  always_comb begin
    decoded = '0;
    decoded.rd = instWord[25:21];
    decoded.ra = instWord[20:16];
    decoded.rb = instWord[15:11];
    decoded.immVal = {{16{instWord[15]}}, instWord[15:0]};
    decoded.opcode = aexmPkg::NOP;
    decoded.aluOp = aexmPkg::ALU_PASS;
    case (instWord[31:26])
      aexmPkg::ADD: begin
        decoded.opcode = aexmPkg::ADD;
        decoded.aluOp = aexmPkg::ALU_ADD;
        decoded.regWrite = 1'b1;
      end
      aexmPkg::RSUB: begin
        decoded.opcode = aexmPkg::RSUB;
        decoded.aluOp = aexmPkg::ALU_RSUB;
        decoded.regWrite = 1'b1;
      end
      aexmPkg::AND: begin
        decoded.opcode = aexmPkg::AND;
        decoded.aluOp = aexmPkg::ALU_AND;
        decoded.regWrite = 1'b1;
      end
      aexmPkg::OR: begin
        decoded.opcode = aexmPkg::OR;
        decoded.aluOp = aexmPkg::ALU_OR;
        decoded.regWrite = 1'b1;
      end
      aexmPkg::XOR: begin
        decoded.opcode = aexmPkg::XOR;
        decoded.aluOp = aexmPkg::ALU_XOR;
        decoded.regWrite = 1'b1;
      end
      aexmPkg::ADDI: begin
        decoded.opcode = aexmPkg::ADDI;
        decoded.aluOp = aexmPkg::ALU_ADD;
        decoded.useImm = 1'b1;
        decoded.regWrite = 1'b1;
      end
      aexmPkg::LW: begin
        decoded.opcode = aexmPkg::LW;
        decoded.aluOp = aexmPkg::ALU_ADD; // Address through the adder
        decoded.useImm = 1'b1;
        decoded.isLoad = 1'b1;
        decoded.regWrite = 1'b1;
      end
      aexmPkg::SW: begin
        decoded.opcode = aexmPkg::SW;
        decoded.aluOp = aexmPkg::ALU_ADD;
        decoded.useImm = 1'b1;
        decoded.isStore = 1'b1;
      end
      aexmPkg::BEQZ: begin
        decoded.opcode = aexmPkg::BEQZ;
        decoded.isBranch = 1'b1;
      end
      aexmPkg::BNEZ: begin
        decoded.opcode = aexmPkg::BNEZ;
        decoded.isBranch = 1'b1;
      end
      default: ;  // Illegal opcodes stay NOP
    endcase
    decoded.valid = validQ & ~kill;
    // Bubble keeps register fields so the hazard check stays loop free
    if (!decoded.valid) begin
      decoded.opcode = aexmPkg::NOP;
      decoded.aluOp = aexmPkg::ALU_PASS;
      decoded.useImm = 1'b0;
      decoded.isLoad = 1'b0;
      decoded.isStore = 1'b0;
      decoded.isBranch = 1'b0;
      decoded.regWrite = 1'b0;
    end
  end

  assign dec_o.dInst = decoded;

  always_ff @(posedge sys_clk_i) begin
    if (!rstN_i) begin
      validQ  <= 1'b0;
      replayQ <= 1'b0;
    end else if (cpuEnable_i) begin
      replayQ <= dec_o.dStall;
      if (!dec_o.dStall) validQ <= ~dec_o.xSkip; // Fetch issued this cycle
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) wordQ <= instWord;
  end

endmodule

// File: verilog/aexmBpcu.sv
`timescale 1ns/1ps

`include "aexm_params.svh"

module aexmBpcu (
  input  logic sys_clk_i,
  input  logic rstN_i,
  input  logic cpuEnable_i,
  aexmDecodeIf.bpcuMp dec_i,
  output logic [`AEXM_IW-1:0] icacheAddr_o
);

  logic [`AEXM_IW-1:0] pcQ;   // Fetch address
  logic [`AEXM_IW-1:0] fPcQ;  // Address of the word in decode
  logic [`AEXM_IW-1:0] xPcQ;  // Address of the instruction in execute
  aexmPkg::wordT brImmQ;
  logic brQ;                  // Valid branch in execute
  logic brNezQ;
  logic taken;

  assign taken = brQ && (brNezQ ? (dec_i.xRegA != '0) : (dec_i.xRegA == '0));
  assign dec_i.xSkip = taken;
  assign icacheAddr_o = pcQ;

  always_ff @(posedge sys_clk_i) begin
    if (!rstN_i) begin
      pcQ <= `AEXM_RESET_PC;
      brQ <= 1'b0;
    end else if (cpuEnable_i) begin
      brQ <= dec_i.dInst.valid & dec_i.dInst.isBranch;
      if (taken)
        pcQ <= xPcQ + brImmQ;   // Restart at target
      else if (!dec_i.dStall)
        pcQ <= pcQ + 'd4;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      if (!dec_i.dStall) fPcQ <= pcQ;
      xPcQ   <= fPcQ;
      brNezQ <= (dec_i.dInst.opcode == aexmPkg::BNEZ);
      brImmQ <= dec_i.dInst.immVal;
    end
  end

endmodule

// File: verilog/aexmRegf.sv
`timescale 1ns/1ps

`include "aexm_params.svh"

module aexmRegf (
  input  logic sys_clk_i,
  input  logic cpuEnable_i,
  aexmDecodeIf.regfMp dec_i,
  input  aexmPkg::regIdxT rRw_i,
  input  logic rRdWe_i,
  input  aexmPkg::wordT rResult_i,
  input  logic loadPending_i,
  input  aexmPkg::wordT dcacheData_i,
  output aexmPkg::wordT dcacheData_o
);

  aexmPkg::wordT regs [`AEXM_NREG];
  aexmPkg::wordT wbData;
  aexmPkg::wordT aQ, bQ, dQ;        // Values read in decode
  aexmPkg::regIdxT raQ, rbQ, rdQ;

  assign wbData = loadPending_i ? dcacheData_i : rResult_i;

  // Read with bypass from the write-back slot
  function automatic aexmPkg::wordT readFwd(input aexmPkg::regIdxT idx);
    if (idx == '0)
      return '0;
    else if (rRdWe_i && (rRw_i == idx))
      return wbData;
    else
      return regs[idx];
  endfunction

  // Execute stage bypass for values read one cycle early
  function automatic aexmPkg::wordT execFwd(input aexmPkg::regIdxT idx,
                                            input aexmPkg::wordT val);
    if (idx != '0 && rRdWe_i && (rRw_i == idx))
      return wbData;
    else
      return val;
  endfunction

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      if (rRdWe_i && (rRw_i != '0)) regs[rRw_i] <= wbData;
      aQ  <= readFwd(dec_i.dInst.ra);
      bQ  <= readFwd(dec_i.dInst.rb);
      dQ  <= readFwd(dec_i.dInst.rd);  // Store data source
      raQ <= dec_i.dInst.ra;
      rbQ <= dec_i.dInst.rb;
      rdQ <= dec_i.dInst.rd;
    end
  end

  always_comb begin
    dec_i.xRegA  = execFwd(raQ, aQ);
    dec_i.xRegB  = execFwd(rbQ, bQ);
    dcacheData_o = execFwd(rdQ, dQ);
  end

endmodule

// File: verilog/aexmXecu.sv
`timescale 1ns/1ps

module aexmXecu (
  input  logic sys_clk_i,
  input  logic rstN_i,
  input  logic cpuEnable_i,
  aexmDecodeIf.xecuMp dec_i,
  output aexmPkg::wordT xResult_o,
  output aexmPkg::wordT rResult_o,
  output aexmPkg::regIdxT rRw_o,
  output logic rRdWe_o,
  output aexmPkg::wordT dcacheAddr_o,
  output logic dcacheWe_o
);

  aexmPkg::decInstT xInst;   // Instruction in execute
  aexmPkg::wordT opB;

  assign opB = xInst.useImm ? xInst.immVal : dec_i.xRegB;

  always_comb begin
    case (xInst.aluOp)
      aexmPkg::ALU_ADD:  xResult_o = dec_i.xRegA + opB;
      aexmPkg::ALU_RSUB: xResult_o = opB - dec_i.xRegA;
      aexmPkg::ALU_AND:  xResult_o = dec_i.xRegA & opB;
      aexmPkg::ALU_OR:   xResult_o = dec_i.xRegA | opB;
      aexmPkg::ALU_XOR:  xResult_o = dec_i.xRegA ^ opB;
      default:           xResult_o = dec_i.xRegA; // ALU_PASS
    endcase
  end

  // Word address, no byte lanes
  assign dcacheAddr_o = dec_i.xRegA + xInst.immVal;
  assign dcacheWe_o   = rstN_i & cpuEnable_i & xInst.valid & xInst.isStore;

  always_ff @(posedge sys_clk_i) begin
    if (!rstN_i) begin
      xInst   <= '0;
      rRdWe_o <= 1'b0;
    end else if (cpuEnable_i) begin
      xInst   <= dec_i.dInst;
      rRdWe_o <= xInst.valid & xInst.regWrite & (xInst.rd != '0); // r0 never written
    end
  end

  // Write-back slot, one cycle after execute
  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      rResult_o <= xResult_o;
      rRw_o     <= xInst.rd;
    end
  end

endmodule

// File: verilog/aexmCore.sv
`timescale 1ns/1ps

`include "aexm_params.svh"

module aexmCore (
  input  logic sys_clk_i,
  input  logic rstN_i,
  output logic [`AEXM_IW-1:0] icachePrecycleAddr_o,
  output logic icachePrecycleEnable_o,
  input  logic [`AEXM_DW-1:0] icacheData_i,
  input  logic icacheBusy_i,
  output logic [`AEXM_DW-1:0] dcachePrecycleAddr_o,
  output logic [`AEXM_DW-1:0] dcacheData_o,
  output logic dcachePrecycleWe_o,
  output logic dcachePrecycleEnable_o,
  input  logic [`AEXM_DW-1:0] dcacheData_i,
  input  logic dcacheBusy_i
);

  logic cpuEnable;
  logic loadPending;
  logic rRdWe;
  aexmPkg::regIdxT rRw;
  aexmPkg::wordT rResult;

  aexmDecodeIf decIf ();

  aexmEnable enable (
    .sys_clk_i      (sys_clk_i),
    .rstN_i         (rstN_i),
    .icacheBusy_i   (icacheBusy_i),
    .dcacheBusy_i   (dcacheBusy_i),
    .dec_i          (decIf.enableMp),
    .loadPending_o  (loadPending),
    .cpuEnable_o    (cpuEnable),
    .icacheEnable_o (icachePrecycleEnable_o),
    .dcacheEnable_o (dcachePrecycleEnable_o)
  );

  aexmIbuf ibuf (
    .sys_clk_i    (sys_clk_i),
    .rstN_i       (rstN_i),
    .cpuEnable_i  (cpuEnable),
    .icacheData_i (icacheData_i),
    .dec_o        (decIf.ibufMp)
  );

  aexmBpcu bpcu (
    .sys_clk_i    (sys_clk_i),
    .rstN_i       (rstN_i),
    .cpuEnable_i  (cpuEnable),
    .dec_i        (decIf.bpcuMp),
    .icacheAddr_o (icachePrecycleAddr_o)
  );

  aexmRegf regf (
    .sys_clk_i     (sys_clk_i),
    .cpuEnable_i   (cpuEnable),
    .dec_i         (decIf.regfMp),
    .rRw_i         (rRw),
    .rRdWe_i       (rRdWe),
    .rResult_i     (rResult),
    .loadPending_i (loadPending),
    .dcacheData_i  (dcacheData_i),
    .dcacheData_o  (dcacheData_o)
  );

  aexmXecu xecu (
    .sys_clk_i    (sys_clk_i),
    .rstN_i       (rstN_i),
    .cpuEnable_i  (cpuEnable),
    .dec_i        (decIf.xecuMp),
    .xResult_o    (),
    .rResult_o    (rResult),
    .rRw_o        (rRw),
    .rRdWe_o      (rRdWe),
    .dcacheAddr_o (dcachePrecycleAddr_o),
    .dcacheWe_o   (dcachePrecycleWe_o)
  );

endmodule

// File: sim/tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen #(
  parameter int PeriodNs = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;  // Rising edges at odd half periods
  end

endmodule

// File: sim/aexm_checker.sv
`timescale 1ns/1ps

`include "aexm_params.svh"

module aexm_checker (
  input logic sys_clk_i,
  input logic rstN_i,
  input logic icacheBusy_i,
  input logic dcacheBusy_i,
  input logic icacheEnable_i,
  input logic [`AEXM_IW-1:0] icacheAddr_i,
  input logic dcacheEnable_i,
  input logic dcacheWe_i
);

  int failCount = 0;  // Failed assertion tally

  // Reset keeps every strobe low
  resetQuiet: assert property (@(posedge sys_clk_i)
    !rstN_i |-> !icacheEnable_i && !dcacheEnable_i && !dcacheWe_i)
    else begin
      failCount++;
      $error("cache strobe high while reset is held");
    end

  // First cycle out of reset fetches the reset vector
  firstFetch: assert property (@(posedge sys_clk_i)
    $rose(rstN_i) && !icacheBusy_i && !dcacheBusy_i |->
      icacheEnable_i && (icacheAddr_i == `AEXM_RESET_PC))
    else begin
      failCount++;
      $error("first fetch after reset missing or not at the reset vector");
    end

  weWithEnable: assert property (@(posedge sys_clk_i) dcacheWe_i |-> dcacheEnable_i)
    else begin
      failCount++;
      $error("dcache write strobe without dcache enable");
    end

endmodule

// File: sim/aexmCoreTb.sv
`timescale 1ns/1ps

`include "aexm_params.svh"

module aexmCoreTb;

  localparam int BodyLen = 360;
  localparam int ProgLen = 31 + BodyLen + 1;      // Register setup, body, final loop
  localparam logic [31:0] FinalPc = (ProgLen - 1) * 4;
  localparam int Margin = 200;

  logic sysClk;
  logic rstN;
  logic [`AEXM_IW-1:0] icacheAddr;
  logic icacheEn, icacheBusy, dcacheWe, dcacheEn, dcacheBusy;
  aexmPkg::wordT icacheData, dcacheAddr, dcacheWdata, dcacheRdata;

  aexmPkg::wordT imem [1024];
  aexmPkg::wordT dmem [256];      // Data cache contents seen by the DUT
  aexmPkg::wordT refMem [256];
  aexmPkg::wordT refReg [`AEXM_NREG];
  aexmPkg::wordT expAddr [$];
  aexmPkg::wordT expData [$];
  logic [`AEXM_IW-1:0] pathPc [$];
  logic pathTaken [$];
  logic [31:0] rngState;
  int squashLeft, finalFetches, cycles, busyCycles, storesSeen;

  tbClockGen #(.PeriodNs(100)) clkGen (.clk_o(sysClk));

  aexmCore dut0 (
    .sys_clk_i              (sysClk),
    .rstN_i                 (rstN),
    .icachePrecycleAddr_o   (icacheAddr),
    .icachePrecycleEnable_o (icacheEn),
    .icacheData_i           (icacheData),
    .icacheBusy_i           (icacheBusy),
    .dcachePrecycleAddr_o   (dcacheAddr),
    .dcacheData_o           (dcacheWdata),
    .dcachePrecycleWe_o     (dcacheWe),
    .dcachePrecycleEnable_o (dcacheEn),
    .dcacheData_i           (dcacheRdata),
    .dcacheBusy_i           (dcacheBusy)
  );

  bind aexmCore aexm_checker checker0 (
    .sys_clk_i      (sys_clk_i),
    .rstN_i         (rstN_i),
    .icacheBusy_i   (icacheBusy_i),
    .dcacheBusy_i   (dcacheBusy_i),
    .icacheEnable_i (icachePrecycleEnable_o),
    .icacheAddr_i   (icachePrecycleAddr_o),
    .dcacheEnable_i (dcachePrecycleEnable_o),
    .dcacheWe_i     (dcachePrecycleWe_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] randWord();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  function automatic aexmPkg::wordT encReg(input aexmPkg::opcodeE op,
      input aexmPkg::regIdxT rd, input aexmPkg::regIdxT ra, input aexmPkg::regIdxT rb);
    return {op, rd, ra, rb, 11'd0};
  endfunction

  function automatic aexmPkg::wordT encImm(input aexmPkg::opcodeE op,
      input aexmPkg::regIdxT rd, input aexmPkg::regIdxT ra, input logic [15:0] imm);
    return {op, rd, ra, imm};
  endfunction

  function automatic aexmPkg::opcodeE pickAluOp(input logic [2:0] sel);
    case (sel)
      3'd1, 3'd5: return aexmPkg::RSUB;
      3'd2:       return aexmPkg::AND;
      3'd3:       return aexmPkg::OR;
      3'd4, 3'd7: return aexmPkg::XOR;
      default:    return aexmPkg::ADD;
    endcase
  endfunction

  task automatic abortRun(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic buildProgram();
    logic [31:0] r, s;
    int i, pos, kind, span;
    aexmPkg::regIdxT rd, ra, rb;
    for (i = 0; i < 1024; i++) imem[i] = encReg(aexmPkg::NOP, '0, '0, '0);
    for (i = 1; i < 32; i++) begin  // Registers power up unknown
      s = randWord();
      imem[i - 1] = encImm(aexmPkg::ADDI, aexmPkg::regIdxT'(i), '0, s[15:0]);
    end
    pos = 31;
    while (pos < ProgLen - 1) begin
      r = randWord();
      s = randWord();
      kind = r % 100;
      rd = r[12:8];
      ra = r[17:13];
      rb = r[22:18];
      if (kind < 40) begin
        imem[pos] = encReg(pickAluOp(r[26:24]), rd, ra, rb);
      end else if (kind < 55) begin
        imem[pos] = encImm(aexmPkg::ADDI, rd, ra, s[15:0]);
      end else if (kind < 85) begin
        if (s[20]) begin  // Small addresses off r0 so loads meet earlier stores
          ra = '0;
          s[15:8] = '0;
        end
        imem[pos] = encImm(kind < 70 ? aexmPkg::LW : aexmPkg::SW, rd, ra, s[15:0]);
        if (kind < 70 && pos + 1 < ProgLen - 1) begin
          pos++;                    // Consumer right behind the load
          if (s[21])
            imem[pos] = encImm(aexmPkg::SW, rd, '0, {8'h00, r[7:0]});
          else
            imem[pos] = encReg(aexmPkg::ADD, rb, rd, ra);
        end
      end else begin
        span = 1 + s[1:0];
        if (pos + span > ProgLen - 1) span = ProgLen - 1 - pos;
        imem[pos] = encImm(s[3] ? aexmPkg::BNEZ : aexmPkg::BEQZ, '0,
                           s[2] ? 5'd0 : ra, 16'(span * 4));
      end
      pos++;
    end
    imem[ProgLen - 1] = encImm(aexmPkg::BEQZ, '0, '0, 16'd0);  // Branch to itself
  endtask

  // Architectural model, one instruction per step
  task automatic runModel();
    logic [`AEXM_IW-1:0] pc;
    aexmPkg::wordT inst, a, b, imm, addr, res;
    aexmPkg::regIdxT rd;
    logic taken, wr;
    int i;
    for (i = 0; i < `AEXM_NREG; i++) refReg[i] = '0;
    pc = `AEXM_RESET_PC;
    while (pc != FinalPc) begin
      inst = imem[pc[11:2]];
      rd = inst[25:21];
      a = refReg[inst[20:16]];
      b = refReg[inst[15:11]];
      imm = {{16{inst[15]}}, inst[15:0]};
      addr = a + imm;
      taken = 1'b0;
      wr = 1'b1;
      res = '0;
      case (inst[31:26])
        aexmPkg::ADD:  res = a + b;
        aexmPkg::RSUB: res = b - a;
        aexmPkg::AND:  res = a & b;
        aexmPkg::OR:   res = a | b;
        aexmPkg::XOR:  res = a ^ b;
        aexmPkg::ADDI: res = a + imm;
        aexmPkg::LW:   res = refMem[addr[7:0]];
        aexmPkg::SW: begin
          wr = 1'b0;
          refMem[addr[7:0]] = refReg[rd];
          expAddr.push_back(addr);
          expData.push_back(refReg[rd]);
        end
        aexmPkg::BEQZ: begin
          wr = 1'b0;
          taken = (a == '0);
        end
        aexmPkg::BNEZ: begin
          wr = 1'b0;
          taken = (a != '0);
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != '0) refReg[rd] = res;   // r0 stays zero
      pathPc.push_back(pc);
      pathTaken.push_back(taken);
      pc = taken ? pc + imm : pc + 4;
    end
  endtask

  task automatic checkFetch(input logic [`AEXM_IW-1:0] addr);
    logic [`AEXM_IW-1:0] expPc;
    logic taken;
    if (pathPc.size() == 0) begin  // Past the end the path loops on the final branch
      pathPc.push_back(FinalPc);
      pathTaken.push_back(1'b1);
    end
    expPc = pathPc.pop_front();
    taken = pathTaken.pop_front();
    if (addr !== expPc) abortRun($sformatf("fetch address %h, expected %h", addr, expPc));
    if (expPc == FinalPc) finalFetches++;
    if (taken) squashLeft = 2;
  endtask

  task automatic checkStore(input aexmPkg::wordT addr, input aexmPkg::wordT data);
    aexmPkg::wordT eAddr;
    aexmPkg::wordT eData;
    if (expAddr.size() == 0) begin
      abortRun($sformatf("store to %h data %h beyond the expected stores", addr, data));
    end else begin
      eAddr = expAddr.pop_front();
      eData = expData.pop_front();
      storesSeen++;
      if (addr !== eAddr || data !== eData)
        abortRun($sformatf("store %0d to %h data %h, expected %h data %h",
                           storesSeen, addr, data, eAddr, eData));
    end
  endtask

  initial begin : mainRun
    logic iEn, dEn, dWe;
    logic [`AEXM_IW-1:0] iAddr;
    aexmPkg::wordT dAddr, dData;
    logic [31:0] r;
    int i;
    rstN = 1'b0;
    icacheData = '0;
    icacheBusy = 1'b0;
    dcacheRdata = '0;
    dcacheBusy = 1'b0;
    rngState = 32'd47663;
    squashLeft = 0;
    finalFetches = 0;
    cycles = 0;
    busyCycles = 0;
    storesSeen = 0;
    for (i = 0; i < 256; i++) begin
      dmem[i] = 32'h9E37_79B9 * (i + 1);
      refMem[i] = dmem[i];
    end
    buildProgram();
    runModel();
    repeat (8) @(posedge sysClk);
    #1;
    rstN = 1'b1;
    while (finalFetches < 2) begin
      @(negedge sysClk);  // Strobes settled
      cycles++;
      if (cycles > 8 * ProgLen + busyCycles + Margin)
        abortRun("core hang, cycle limit passed before the program finished");
      if (dut0.checker0.failCount != 0)
        abortRun("a bound assertion on reset or cache strobes failed");
      if ($isunknown({icacheEn, dcacheEn, dcacheWe}))
        abortRun("a cache strobe is unknown");
      iEn = icacheEn;
      iAddr = icacheAddr;
      dEn = dcacheEn;
      dWe = dcacheWe;
      dAddr = dcacheAddr;
      dData = dcacheWdata;
      if (iEn) begin
        if (squashLeft > 0)
          squashLeft--;       // Wrong path behind a taken branch
        else
          checkFetch(iAddr);
      end
      if (dEn && dWe) checkStore(dAddr, dData);
      @(posedge sysClk);
      #1;
      if (iEn) icacheData = imem[iAddr[11:2]];
      if (dEn && dWe)
        dmem[dAddr[7:0]] = dData;
      else if (dEn)
        dcacheRdata = dmem[dAddr[7:0]];
      r = randWord();
      icacheBusy = (r[2:0] == 3'd0);
      dcacheBusy = (r[10:8] == 3'd0);
      if (icacheBusy || dcacheBusy) busyCycles++;
    end
    if (dut0.checker0.failCount != 0) begin
      abortRun("a bound assertion on reset or cache strobes failed");
    end else if (expAddr.size() != 0) begin
      abortRun($sformatf("%0d expected stores never appeared", expAddr.size()));
    end else begin
      $display("%0d stores matched over %0d cycles, %0d busy", storesSeen, cycles, busyCycles);
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: project.f
+incdir+verilog
verilog/aexmPkg.sv
verilog/aexmDecodeIf.sv
verilog/aexmEnable.sv
verilog/aexmIbuf.sv
verilog/aexmBpcu.sv
verilog/aexmRegf.sv
verilog/aexmXecu.sv
verilog/aexmCore.sv
sim/tbClockGen.sv
sim/aexm_checker.sv
sim/aexmCoreTb.sv
